// ==== list.f ====
hdl/math_pkg.sv
hdl/bus_pkg.sv
hdl/mem_wr_if.sv
hdl/mac_ctrl_if.sv
hdl/lint_slave.sv
hdl/sample_ram.sv
hdl/mac_lane.sv
hdl/math_unit.sv
hdl/efpga_math_top.sv
tb/tb_clk_gen.sv
tb/tb_efpga_math.sv

// ==== tb/tb_efpga_math.sv ====
`timescale 1ns/1ps
`default_nettype none
// testbench for the eFPGA math unit
// loads samples over lint, runs both lanes and checks results against a model
module tb_efpga_math;
  import bus_pkg::*;
  import math_pkg::*;

  localparam int N_RUNS  = 14;
  localparam int N_LOADS = 10;
  // every run and every full load of the three memories with a 2x margin
  localparam int BUDGET_CYC = 2 * (N_RUNS * (RAM_DEPTH + 20) + N_LOADS * 3 * RAM_DEPTH + 16);

  logic       clk0;
  logic       arst_n;
  logic       lint_req;
  logic       lint_wen;
  lint_addr_t lint_addr;
  data_t      lint_wdata;
  logic       lint_gnt;
  logic       lint_valid;
  data_t      lint_rdata;

  integer  seed;
  sample_t oper0_m [RAM_DEPTH];
  sample_t oper1_m [RAM_DEPTH];
  sample_t coef_m  [RAM_DEPTH];

  logic  chk_req;  // request in flight has an expected read value
  data_t chk_exp;
  logic  req_seen;
  logic  chk_seen;
  data_t exp_seen;

  tb_clk_gen u_clk_gen (
    .clk0   (clk0),
    .arst_n (arst_n)
  );

  efpga_math_top i_efpga_math_top (
    .clk0       (clk0),
    .arst_n     (arst_n),
    .lint_req   (lint_req),
    .lint_wen   (lint_wen),
    .lint_addr  (lint_addr),
    .lint_wdata (lint_wdata),
    .lint_gnt   (lint_gnt),
    .lint_valid (lint_valid),
    .lint_rdata (lint_rdata)
  );

  task automatic end_in_failure();
    $display("Test failures found");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  function automatic lint_addr_t mem_addr(input region_e r, input int idx);
    lint_addr_t a;
    a = '0;
    a[13:12] = r;
    a[9:2] = idx[7:0];
    return a;
  endfunction

  function automatic lint_addr_t reg_addr(input logic [7:0] idx);
    return mem_addr(region_regs, int'(idx));
  endfunction

  function automatic data_t ctrl_word(input logic start, input logic tc, input logic rnd,
                                      input logic sat, input int outsel);
    data_t w;
    w = '0;
    w[START_BIT] = start;
    w[TC_BIT] = tc;
    w[RND_BIT] = rnd;
    w[SAT_BIT] = sat;
    w[OUTSEL_LSB +: $bits(shift_t)] = shift_t'(outsel);
    return w;
  endfunction

  // full-precision sum, then round, shift and saturate
  function automatic data_t expected_result(input sample_t op [RAM_DEPTH],
                                            input sample_t cf [RAM_DEPTH], input int len,
                                            input logic tc, input logic rnd, input logic sat,
                                            input int outsel);
    longint sum;
    longint a;
    longint b;
    sum = 0;
    for (int i = 0; i < len; i++) begin
      if (tc) begin
        a = longint'($signed(op[i]));
        b = longint'($signed(cf[i]));
      end else begin
        a = longint'(op[i]);
        b = longint'(cf[i]);
      end
      sum = sum + a * b;
    end
    if (rnd && outsel > 0)
      sum = sum + (longint'(1) << (outsel - 1));
    sum = sum >>> outsel;
    if (sat && tc && sum > 64'sd2147483647)
      return 32'h7fff_ffff;
    if (sat && tc && sum < -64'sd2147483648)
      return 32'h8000_0000;
    if (sat && !tc && sum > 64'sd4294967295)
      return 32'hffff_ffff;
    return sum[31:0];
  endfunction

  // one request cycle left asserted for back-to-back use
  task automatic issue(input logic rd, input lint_addr_t a, input data_t wd,
                       input logic chk, input data_t exp);
    @(posedge clk0);
    lint_req   <= 1'b1;
    lint_wen   <= rd;
    lint_addr  <= a;
    lint_wdata <= wd;
    chk_req    <= chk;
    chk_exp    <= exp;
  endtask

  task automatic bus_idle();
    @(posedge clk0);
    lint_req <= 1'b0;
    chk_req  <= 1'b0;
  endtask

  task automatic write_word(input lint_addr_t a, input data_t d);
    issue(1'b0, a, d, 1'b0, '0);
    bus_idle();
  endtask

  task automatic read_word(input lint_addr_t a, output data_t d);
    int waits;
    issue(1'b1, a, '0, 1'b0, '0);
    bus_idle();
    waits = 0;
    @(negedge clk0);
    while (!lint_valid && waits < 4) begin
      @(negedge clk0);
      waits++;
    end
    if (!lint_valid) begin
      $display("no lint_valid seen after a read request");
      end_in_failure();
    end
    d = lint_rdata;
  endtask

  task automatic read_expect(input lint_addr_t a, input data_t exp);
    issue(1'b1, a, '0, 1'b1, exp);
    bus_idle();
  endtask

  task automatic fill_random();
    for (int i = 0; i < RAM_DEPTH; i++) begin
      oper0_m[i] = $random(seed);
      oper1_m[i] = $random(seed);
      coef_m[i]  = $random(seed);
    end
  endtask

  task automatic load_mems();
    for (int i = 0; i < RAM_DEPTH; i++)
      issue(1'b0, mem_addr(region_oper0, i), data_t'(oper0_m[i]), 1'b0, '0);
    for (int i = 0; i < RAM_DEPTH; i++)
      issue(1'b0, mem_addr(region_oper1, i), data_t'(oper1_m[i]), 1'b0, '0);
    for (int i = 0; i < RAM_DEPTH; i++)
      issue(1'b0, mem_addr(region_coef, i), data_t'(coef_m[i]), 1'b0, '0);
    bus_idle();
  endtask

  task automatic start_run(input logic tc, input logic rnd, input logic sat, input int outsel);
    write_word(reg_addr(REG_CTRL), ctrl_word(1'b1, tc, rnd, sat, outsel));
  endtask

  task automatic wait_done();
    data_t st;
    int    polls;
    st = '0;
    polls = 0;
    while (!st[DONE_BIT]) begin
      if (polls == 4 * RAM_DEPTH) begin
        $display("run never finished, STATUS done bit stayed low");
        end_in_failure();
      end
      read_word(reg_addr(REG_STATUS), st);
      polls++;
    end
    check("status", st, 32'h2);  // done without busy
  endtask

  task automatic check_results(input data_t e0, input data_t e1);
    issue(1'b1, reg_addr(REG_RESULT0), '0, 1'b1, e0);
    issue(1'b1, reg_addr(REG_RESULT1), '0, 1'b1, e1);
    bus_idle();
  endtask

  task automatic run_and_check(input int len, input logic tc, input logic rnd,
                               input logic sat, input int outsel,
                               input data_t e0, input data_t e1);
    write_word(reg_addr(REG_LEN), data_t'(len));
    start_run(tc, rnd, sat, outsel);
    wait_done();
    check_results(e0, e1);
  endtask

  task automatic random_runs(input logic tc, input int n);
    int    k;
    int    len;
    int    outsel;
    logic  rnd;
    logic  sat;
    data_t e0;
    data_t e1;
    for (k = 0; k < n; k++) begin
      fill_random();
      load_mems();
      if (k == 0)
        len = 0;
      else if (k == 1)
        len = RAM_DEPTH;
      else
        len = {$random(seed)} % (RAM_DEPTH + 1);
      outsel = {$random(seed)} % 40;
      rnd = $random(seed);
      sat = $random(seed);
      e0 = expected_result(oper0_m, coef_m, len, tc, rnd, sat, outsel);
      e1 = expected_result(oper1_m, coef_m, len, tc, rnd, sat, outsel);
      run_and_check(len, tc, rnd, sat, outsel, e0, e1);
    end
  endtask

  // handshake and read data checked every cycle
  always @(negedge clk0) begin
    if (arst_n === 1'b1) begin
      check("lint_gnt", data_t'(lint_gnt), data_t'(lint_req));
      check("lint_valid", data_t'(lint_valid), data_t'(req_seen));
      if (chk_seen)
        check("lint_rdata", lint_rdata, exp_seen);
      req_seen = lint_req;
      chk_seen = lint_req & chk_req;
      exp_seen = chk_exp;
    end
  end

  initial begin
    repeat (BUDGET_CYC) @(posedge clk0);
    $display("timeout, the tests ran longer than the watchdog allows");
    end_in_failure();
  end

  initial begin
    data_t e0;
    data_t e1;
    seed       = 32'hccd4;
    lint_req   = 1'b0;
    lint_wen   = 1'b1;
    lint_addr  = '0;
    lint_wdata = '0;
    chk_req    = 1'b0;
    chk_exp    = '0;
    req_seen   = 1'b0;
    chk_seen   = 1'b0;
    exp_seen   = '0;
    wait (arst_n === 1'b1);

    // reset values read back to back
    issue(1'b1, reg_addr(REG_STATUS), '0, 1'b1, '0);
    issue(1'b1, reg_addr(REG_RESULT0), '0, 1'b1, '0);
    issue(1'b1, reg_addr(REG_RESULT1), '0, 1'b1, '0);
    issue(1'b1, reg_addr(REG_VERSION), '0, 1'b1, data_t'(VERSION));
    issue(1'b1, reg_addr(REG_CTRL), '0, 1'b1, '0);
    bus_idle();

    // mixed burst where memory reads give zero
    issue(1'b0, mem_addr(region_oper0, 3), 32'h1234, 1'b0, '0);
    issue(1'b1, mem_addr(region_oper0, 3), '0, 1'b1, '0);
    issue(1'b0, reg_addr(REG_LEN), 32'd7, 1'b0, '0);
    issue(1'b1, reg_addr(REG_VERSION), '0, 1'b1, data_t'(VERSION));
    issue(1'b1, mem_addr(region_coef, 200), '0, 1'b1, '0);
    bus_idle();

    random_runs(1'b1, 4);
    random_runs(1'b0, 4);

    // large sums with a small shift
    for (int i = 0; i < RAM_DEPTH; i++) begin
      oper0_m[i] = 16'h8000 + 16'(i);
      oper1_m[i] = 16'h7fff - 16'(i);
      coef_m[i]  = 16'h8000 + 16'(i);
    end
    load_mems();
    run_and_check(RAM_DEPTH, 1'b1, 1'b0, 1'b1, 3, 32'h7fff_ffff, 32'h8000_0000);
    e0 = expected_result(oper0_m, coef_m, RAM_DEPTH, 1'b1, 1'b0, 1'b0, 3);
    e1 = expected_result(oper1_m, coef_m, RAM_DEPTH, 1'b1, 1'b0, 1'b0, 3);
    run_and_check(RAM_DEPTH, 1'b1, 1'b0, 1'b0, 3, e0, e1);
    run_and_check(RAM_DEPTH, 1'b0, 1'b0, 1'b1, 2, 32'hffff_ffff, 32'hffff_ffff);
    e0 = expected_result(oper0_m, coef_m, RAM_DEPTH, 1'b0, 1'b0, 1'b0, 2);
    e1 = expected_result(oper1_m, coef_m, RAM_DEPTH, 1'b0, 1'b0, 1'b0, 2);
    run_and_check(RAM_DEPTH, 1'b0, 1'b0, 1'b0, 2, e0, e1);

    // writes while busy must be dropped
    fill_random();
    load_mems();
    e0 = expected_result(oper0_m, coef_m, RAM_DEPTH, 1'b1, 1'b1, 1'b0, 12);
    e1 = expected_result(oper1_m, coef_m, RAM_DEPTH, 1'b1, 1'b1, 1'b0, 12);
    write_word(reg_addr(REG_LEN), data_t'(RAM_DEPTH));
    start_run(1'b1, 1'b1, 1'b0, 12);
    read_expect(reg_addr(REG_STATUS), 32'h1);
    for (int i = 0; i < 8; i++)
      issue(1'b0, mem_addr(region_coef, i), data_t'(~coef_m[i]), 1'b0, '0);
    issue(1'b0, reg_addr(REG_LEN), 32'd3, 1'b0, '0);
    issue(1'b0, reg_addr(REG_CTRL), ctrl_word(1'b1, 1'b0, 1'b0, 1'b1, 0), 1'b0, '0);
    bus_idle();
    wait_done();
    check_results(e0, e1);
    start_run(1'b1, 1'b1, 1'b0, 12);  // same length and data as before
    wait_done();
    check_results(e0, e1);

    repeat (3) @(posedge clk0);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
// testbench clock and reset
// 40 ns clock, reset held low for the first 16 cycles
module tb_clk_gen (
  output logic clk0,
  output logic arst_n
);

  initial begin
    clk0 = 1'b0;
    forever #20 clk0 = ~clk0;  // half period
  end

  initial begin
    arst_n = 1'b0;
    repeat (16) @(posedge clk0);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== hdl/efpga_math_top.sv ====
`timescale 1ns/1ps
`default_nettype none
// eFPGA math unit top level
// lint bus slave in front of the two-lane MAC unit
module efpga_math_top (
  input  logic                clk0,
  input  logic                arst_n,
  input  logic                lint_req,
  input  logic                lint_wen,    // 1 means read
  input  bus_pkg::lint_addr_t lint_addr,
  input  bus_pkg::data_t      lint_wdata,
  output logic                lint_gnt,
  output logic                lint_valid,
  output bus_pkg::data_t      lint_rdata
);

  mem_wr_if   mem_wr ();
  mac_ctrl_if mac_ctrl ();

  lint_slave u_lint_slave (
    .clk0       (clk0),
    .arst_n     (arst_n),
    .lint_req   (lint_req),
    .lint_wen   (lint_wen),
    .lint_addr  (lint_addr),
    .lint_wdata (lint_wdata),
    .lint_gnt   (lint_gnt),
    .lint_valid (lint_valid),
    .lint_rdata (lint_rdata),
    .mem        (mem_wr.slave),
    .mac        (mac_ctrl.ctrl)
  );

  math_unit u_math_unit (
    .clk0   (clk0),
    .arst_n (arst_n),
    .mem    (mem_wr.ram),
    .mac    (mac_ctrl.unit)
  );

endmodule

`default_nettype wire

// ==== hdl/math_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
// math unit
// run sequencer feeding two MAC lanes from three sample memories
module math_unit (
  input logic      clk0,
  input logic      arst_n,
  mem_wr_if.ram    mem,
  mac_ctrl_if.unit mac
);
  import math_pkg::*;
  import bus_pkg::*;

  typedef enum logic [1:0] {
    idle,
    issue,
    drain
  } state_e;

  state_e    state;
  len_t      cnt;       // next read address
  logic      rd_valid;  // aligned with ram read data
  logic      rd_first;
  ram_addr_t raddr;
  sample_t   oper0_rdata;
  sample_t   oper1_rdata;
  sample_t   coef_rdata;
  data_t     lane0_result;
  data_t     lane1_result;

  assign raddr = ram_addr_t'(cnt);

  sample_ram u_oper0 (
    .clk0  (clk0),
    .we    (mem.we && mem.region == region_oper0),
    .waddr (mem.addr),
    .raddr (raddr),
    .wdata (mem.data),
    .rdata (oper0_rdata)
  );

  sample_ram u_oper1 (
    .clk0  (clk0),
    .we    (mem.we && mem.region == region_oper1),
    .waddr (mem.addr),
    .raddr (raddr),
    .wdata (mem.data),
    .rdata (oper1_rdata)
  );

  sample_ram u_coef (
    .clk0  (clk0),
    .we    (mem.we && mem.region == region_coef),
    .waddr (mem.addr),
    .raddr (raddr),
    .wdata (mem.data),
    .rdata (coef_rdata)
  );

  mac_lane u_lane0 (
    .clk0   (clk0),
    .arst_n (arst_n),
    .en     (rd_valid),
    .first  (rd_first),
    .oper   (oper0_rdata),
    .coef   (coef_rdata),
    .tc     (mac.tc),
    .rnd    (mac.rnd),
    .sat    (mac.sat),
    .outsel (mac.outsel),
    .result (lane0_result)
  );

  mac_lane u_lane1 (
    .clk0   (clk0),
    .arst_n (arst_n),
    .en     (rd_valid),
    .first  (rd_first),
    .oper   (oper1_rdata),
    .coef   (coef_rdata),
    .tc     (mac.tc),
    .rnd    (mac.rnd),
    .sat    (mac.sat),
    .outsel (mac.outsel),
    .result (lane1_result)
  );

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state       <= idle;
      cnt         <= '0;
      rd_valid    <= 1'b0;
      rd_first    <= 1'b0;
      mac.busy    <= 1'b0;
      mac.done    <= 1'b0;
      mac.result0 <= '0;
      mac.result1 <= '0;
    end else begin
      rd_valid <= state == issue;
      rd_first <= state == issue && cnt == '0;
      case (state)
        idle: begin
          if (mac.start) begin
            mac.busy <= 1'b1;
            mac.done <= 1'b0;
            cnt      <= '0;
            state    <= (mac.length == '0) ? drain : issue;
          end
        end
        issue: begin
          cnt <= cnt + 1'b1;
          if (cnt == len_t'(mac.length - 1'b1)) begin
            state <= drain;
          end
        end
        drain: begin
          // last item has left the accumulators once rd_valid drops
          if (!rd_valid) begin
            mac.busy    <= 1'b0;
            mac.done    <= 1'b1;
            mac.result0 <= (mac.length == '0) ? '0 : lane0_result;
            mac.result1 <= (mac.length == '0) ? '0 : lane1_result;
            state       <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mac_lane.sv ====
`timescale 1ns/1ps
`default_nettype none
// multiply-accumulate lane
// 16x16 MAC into 40 bits, with round, shift and saturate on the way out
module mac_lane (
  input  logic              clk0,
  input  logic              arst_n,
  input  logic              en,
  input  logic              first,
  input  math_pkg::sample_t oper,
  input  math_pkg::sample_t coef,
  input  logic              tc,
  input  logic              rnd,
  input  logic              sat,
  input  math_pkg::shift_t  outsel,
  output bus_pkg::data_t    result
);
  import math_pkg::*;
  import bus_pkg::*;

  logic signed [SAMPLE_W:0]     oper_x;  // extra bit makes unsigned mode positive
  logic signed [SAMPLE_W:0]     coef_x;
  logic signed [2*SAMPLE_W+1:0] prod;
  acc_t                         acc;
  logic signed [ACC_W+1:0]      acc_x;   // headroom for the round add
  logic signed [ACC_W+1:0]      rnd_add;
  logic signed [ACC_W+1:0]      shifted;
  logic                         ovf;
  data_t                        clamp;

  assign oper_x = {tc & oper[SAMPLE_W-1], oper};
  assign coef_x = {tc & coef[SAMPLE_W-1], coef};
  assign prod   = oper_x * coef_x;

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      acc <= '0;
    end else if (en) begin
      acc <= first ? acc_t'(prod) : acc + acc_t'(prod);
    end
  end

  assign acc_x = {{2{tc & acc[ACC_W-1]}}, acc};

  // half an output lsb
  always_comb begin
    rnd_add = '0;
    if (rnd && outsel != '0) begin
      rnd_add[outsel - 1'b1] = 1'b1;
    end
  end

  assign shifted = (acc_x + rnd_add) >>> outsel;

  always_comb begin
    if (tc) begin
      ovf   = !((&shifted[ACC_W+1:DATA_W-1]) || !(|shifted[ACC_W+1:DATA_W-1]));
      clamp = shifted[ACC_W+1] ? {1'b1, {(DATA_W-1){1'b0}}} : {1'b0, {(DATA_W-1){1'b1}}};
    end else begin
      ovf   = |shifted[ACC_W+1:DATA_W];
      clamp = '1;  // never below zero here
    end
  end

  assign result = (sat && ovf) ? clamp : shifted[DATA_W-1:0];

endmodule

`default_nettype wire

// ==== hdl/sample_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
// sample memory
// RAM_DEPTH words, one write port, one registered read port
module sample_ram (
  input  logic                clk0,
  input  logic                we,
  input  math_pkg::ram_addr_t waddr,
  input  math_pkg::ram_addr_t raddr,
  input  math_pkg::sample_t   wdata,
  output math_pkg::sample_t   rdata
);
  import math_pkg::*;

  sample_t mem [RAM_DEPTH];

  always_ff @(posedge clk0) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // one cycle read latency
  end

endmodule

`default_nettype wire

// ==== hdl/lint_slave.sv ====
`timescale 1ns/1ps
`default_nettype none
// lint slave
// grants every request at once, decodes it and answers one cycle later
module lint_slave (
  input  logic                clk0,
  input  logic                arst_n,
  input  logic                lint_req,
  input  logic                lint_wen,
  input  bus_pkg::lint_addr_t lint_addr,
  input  bus_pkg::data_t      lint_wdata,
  output logic                lint_gnt,
  output logic                lint_valid,
  output bus_pkg::data_t      lint_rdata,
  mem_wr_if.slave             mem,
  mac_ctrl_if.ctrl            mac
);
  import bus_pkg::*;
  import math_pkg::*;

  region_e    region;
  logic [7:0] word_idx;
  logic       wr_req;
  logic       rd_req;
  logic       ctrl_wr;
  logic       len_wr;
  data_t      rd_word;

  assign region   = region_e'(lint_addr[13:12]);
  assign word_idx = lint_addr[9:2];

  assign wr_req  = lint_req & ~lint_wen & ~mac.busy;  // writes dropped during a run
  assign rd_req  = lint_req & lint_wen;
  assign ctrl_wr = wr_req && region == region_regs && word_idx == REG_CTRL;
  assign len_wr  = wr_req && region == region_regs && word_idx == REG_LEN;

  assign lint_gnt = lint_req;

  // memory beat goes out in the request cycle
  assign mem.we     = wr_req && region != region_regs;
  assign mem.region = region;
  assign mem.addr   = ram_addr_t'(word_idx);
  assign mem.data   = lint_wdata[SAMPLE_W-1:0];

  assign mac.start = ctrl_wr & lint_wdata[START_BIT];  // busy rises next cycle

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      mac.tc     <= 1'b0;
      mac.rnd    <= 1'b0;
      mac.sat    <= 1'b0;
      mac.outsel <= '0;
      mac.length <= '0;
    end else begin
      if (ctrl_wr) begin
        mac.tc     <= lint_wdata[TC_BIT];
        mac.rnd    <= lint_wdata[RND_BIT];
        mac.sat    <= lint_wdata[SAT_BIT];
        mac.outsel <= lint_wdata[OUTSEL_LSB +: $bits(shift_t)];
      end
      if (len_wr) begin
        mac.length <= lint_wdata[$bits(len_t)-1:0];
      end
    end
  end

  always_comb begin
    rd_word = '0;
    if (region == region_regs) begin
      case (word_idx)
        REG_STATUS: begin
          rd_word[BUSY_BIT] = mac.busy;
          rd_word[DONE_BIT] = mac.done;
        end
        REG_RESULT0: rd_word = mac.result0;
        REG_RESULT1: rd_word = mac.result1;
        REG_VERSION: rd_word = data_t'(VERSION);
        default:     rd_word = '0;  // ctrl, len and holes
      endcase
    end
  end

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      lint_valid <= 1'b0;
    end else begin
      lint_valid <= lint_req;  // reads and writes alike
    end
  end

  always_ff @(posedge clk0) begin
    if (rd_req) begin
      lint_rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mac_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none
// run control link
// start, length and options to the math unit, status and results back
interface mac_ctrl_if;
  import math_pkg::*;
  import bus_pkg::*;

  logic   start;   // one cycle, only while not busy
  len_t   length;
  logic   tc;
  logic   rnd;
  logic   sat;
  shift_t outsel;

  logic  busy;
  logic  done;
  data_t result0;
  data_t result1;

  modport ctrl (output start, length, tc, rnd, sat, outsel,
                input busy, done, result0, result1);
  modport unit (input start, length, tc, rnd, sat, outsel,
                output busy, done, result0, result1);

endinterface

`default_nettype wire

// ==== hdl/mem_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none
// sample memory write port
// one word per clock edge with we high, routed by region
interface mem_wr_if;
  import math_pkg::*;
  import bus_pkg::*;

  logic      we;
  region_e   region;  // which of the three memories
  ram_addr_t addr;
  sample_t   data;

  modport slave (output we, region, addr, data);
  modport ram (input we, region, addr, data);

endinterface

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
`default_nettype none
// lint bus definitions
// address and data types, region decode and register map of the math unit slave
package bus_pkg;

  localparam int DATA_W = 32;

  typedef logic [19:0]       lint_addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // address bits 13:12
  typedef enum logic [1:0] {
    region_oper0,
    region_oper1,
    region_coef,
    region_regs
  } region_e;

  // word index, address bits 9:2
  localparam logic [7:0] REG_CTRL    = 8'd0;
  localparam logic [7:0] REG_LEN     = 8'd1;
  localparam logic [7:0] REG_STATUS  = 8'd2;
  localparam logic [7:0] REG_RESULT0 = 8'd3;
  localparam logic [7:0] REG_RESULT1 = 8'd4;
  localparam logic [7:0] REG_VERSION = 8'd5;

  localparam int START_BIT  = 0;  // write-only pulse
  localparam int TC_BIT     = 1;
  localparam int RND_BIT    = 2;
  localparam int SAT_BIT    = 3;
  localparam int OUTSEL_LSB = 4;  // outsel in 9:4

  localparam int BUSY_BIT = 0;
  localparam int DONE_BIT = 1;

  localparam logic [7:0] VERSION = 8'h21;

endpackage

`default_nettype wire

// ==== hdl/math_pkg.sv ====
`default_nettype none
// math unit types
// sample, accumulator, shift and run length definitions shared by the MAC datapath
package math_pkg;

  localparam int SAMPLE_W  = 16;
  localparam int ACC_W     = 40;   // 256 full-scale products fit
  localparam int RAM_DEPTH = 256;  // words per sample memory

  // one operand or coefficient, signedness set per run by tc
  typedef logic [SAMPLE_W-1:0] sample_t;

  typedef logic [ACC_W-1:0] acc_t;

  typedef logic [$clog2(RAM_DEPTH)-1:0] ram_addr_t;

  // 0 to RAM_DEPTH inclusive, hence one extra bit
  typedef logic [$clog2(RAM_DEPTH):0] len_t;

  typedef logic [5:0] shift_t;  // outsel, 0..39 used

endpackage

`default_nettype wire
